// File: source/gemm_cfg_pkg.sv
package gemm_cfg_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [7:0]  dim_t;
  typedef logic [7:0]  elem_t;
  typedef logic [31:0] acc_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // --------------------------------------------------
  // csr map
  // --------------------------------------------------
  // size is {8'h0, m, k, n}, sub is {16'h0, sub_b, sub_a}
  localparam csr_addr_t CsrSize  = 12'h3c0;
  localparam csr_addr_t CsrPtrA  = 12'h3c1;
  localparam csr_addr_t CsrPtrB  = 12'h3c2;
  localparam csr_addr_t CsrPtrC  = 12'h3c3;
  localparam csr_addr_t CsrSub   = 12'h3c4;
  localparam csr_addr_t CsrPerf  = 12'h3c5;
  // bit 0 starts a run, bit 1 reads back idle
  localparam csr_addr_t CsrState = 12'h3c6;

  // tile geometry, int8 elements
  localparam int unsigned TileRows  = 2;
  localparam int unsigned TileDepth = 8;
  localparam int unsigned TileBytes = TileRows * TileDepth;

  typedef struct packed {
    dim_t  m;
    dim_t  k;
    dim_t  n;
    addr_t ptr_a;
    addr_t ptr_b;
    addr_t ptr_c;
    elem_t sub_a;
    elem_t sub_b;
  } gemm_cfg_t;

  typedef struct packed {
    logic       write;
    csr_addr_t  addr;
    csr_data_t  wdata;
    logic [4:0] id;
  } csr_req_t;

  typedef struct packed {
    csr_data_t  rdata;
    logic [4:0] id;
  } csr_rsp_t;

endpackage

// File: source/tcdm_pkg.sv
package tcdm_pkg;

  import gemm_cfg_pkg::*;

  localparam int unsigned WordWidth = 64;
  localparam int unsigned WordBytes = WordWidth / 8;

  // ports 0 and 1 fetch A rows, ports 2 and 3 fetch B rows
  localparam int unsigned ReadPorts  = 4;
  localparam int unsigned WritePorts = 2;

  typedef logic [WordWidth-1:0] word_t;

  typedef struct packed {
    logic                 q_valid;
    addr_t                addr;
    logic                 write;
    word_t                data;
    logic [WordBytes-1:0] strb;
  } tcdm_req_t;

  typedef struct packed {
    logic  q_ready;
    logic  p_valid;
    word_t data;
  } tcdm_rsp_t;

endpackage

// File: source/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile
  import gemm_cfg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      csr_qvalid_i,
  output logic      csr_qready_o,
  input  csr_req_t  csr_req_i,
  output logic      csr_pvalid_o,
  input  logic      csr_pready_i,
  output csr_rsp_t  csr_rsp_o,
  input  logic      busy_i,
  output gemm_cfg_t cfg_o,
  output logic      start_o
);

  logic      accept;
  logic      state_wr;
  logic      rsp_valid_q;
  csr_rsp_t  rsp_q;
  csr_data_t rdata;
  csr_data_t perf_q;
  gemm_cfg_t cfg_q;

  // a state write stalls while a run is active, reads stall behind a pending response
  assign state_wr     = csr_req_i.write && (csr_req_i.addr == CsrState);
  assign csr_qready_o = !rsp_valid_q && !(state_wr && busy_i);
  assign accept       = csr_qvalid_i && csr_qready_o;
  assign start_o      = accept && state_wr && csr_req_i.wdata[0];

  always_comb begin
    case (csr_req_i.addr)
      CsrSize:  rdata = {8'h00, cfg_q.m, cfg_q.k, cfg_q.n};
      CsrPtrA:  rdata = cfg_q.ptr_a;
      CsrPtrB:  rdata = cfg_q.ptr_b;
      CsrPtrC:  rdata = cfg_q.ptr_c;
      CsrSub:   rdata = {16'h0000, cfg_q.sub_b, cfg_q.sub_a};
      CsrPerf:  rdata = perf_q;
      CsrState: rdata = {30'h0, !busy_i, 1'b0};
      default:  rdata = '0;
    endcase
  end

  // --------------------------------------------------
  // configuration registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (accept && csr_req_i.write) begin
      case (csr_req_i.addr)
        CsrSize: begin
          cfg_q.m <= csr_req_i.wdata[23:16];
          cfg_q.k <= csr_req_i.wdata[15:8];
          cfg_q.n <= csr_req_i.wdata[7:0];
        end
        CsrPtrA: cfg_q.ptr_a <= csr_req_i.wdata;
        CsrPtrB: cfg_q.ptr_b <= csr_req_i.wdata;
        CsrPtrC: cfg_q.ptr_c <= csr_req_i.wdata;
        CsrSub: begin
          cfg_q.sub_a <= csr_req_i.wdata[7:0];
          cfg_q.sub_b <= csr_req_i.wdata[15:8];
        end
        default: ;
      endcase
    end
  end

  // busy cycles of the last run
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      perf_q <= '0;
    end else if (start_o) begin
      perf_q <= '0;
    end else if (busy_i) begin
      perf_q <= perf_q + csr_data_t'(1);
    end
  end

  // --------------------------------------------------
  // read response
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (accept && !csr_req_i.write) begin
      rsp_valid_q <= 1'b1;
    end else if (csr_pready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !csr_req_i.write) begin
      rsp_q.rdata <= rdata;
      rsp_q.id    <= csr_req_i.id;
    end
  end

  assign csr_pvalid_o = rsp_valid_q;
  assign csr_rsp_o    = rsp_q;
  assign cfg_o        = cfg_q;

  // response held under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_pvalid_o && !csr_pready_i |=> csr_pvalid_o && $stable(csr_rsp_o));

endmodule

// File: source/tile_sequencer.sv
`timescale 1ns/1ps

module tile_sequencer
  import gemm_cfg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  gemm_cfg_t cfg_i,
  input  logic      start_i,
  input  logic      rd_granted_i,
  input  logic      tile_valid_i,
  input  logic      wr_granted_i,
  output logic      rd_valid_o,
  output logic      wr_valid_o,
  output logic      acc_clear_o,
  output logic      busy_o,
  output addr_t     rd_addr_a_o,
  output addr_t     rd_addr_b_o,
  output addr_t     wr_addr_c_o
);

  typedef enum logic [1:0] {IDLE, RD_REQ, RD_WAIT, WRITE} state_e;

  state_e    state_q;
  gemm_cfg_t cfg_q;
  dim_t      m_q;
  dim_t      n_q;
  dim_t      k_q;
  logic      last_k;
  logic      last_n;
  logic      last_m;

  assign last_k = (k_q == cfg_q.k - 8'd1);
  assign last_n = (n_q == cfg_q.n - 8'd1);
  assign last_m = (m_q == cfg_q.m - 8'd1);

  // run configuration is frozen at start
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) begin
      cfg_q <= cfg_i;
    end
  end

  // --------------------------------------------------
  // loop nest m, n, k
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      m_q     <= '0;
      n_q     <= '0;
      k_q     <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= RD_REQ;
            m_q     <= '0;
            n_q     <= '0;
            k_q     <= '0;
          end
        end
        RD_REQ: if (rd_granted_i) state_q <= RD_WAIT;
        RD_WAIT: begin
          if (tile_valid_i) begin
            if (last_k) begin
              k_q     <= '0;
              state_q <= WRITE;
            end else begin
              k_q     <= k_q + 8'd1;
              state_q <= RD_REQ;
            end
          end
        end
        WRITE: begin
          if (wr_granted_i) begin
            state_q <= RD_REQ;
            if (!last_n) begin
              n_q <= n_q + 8'd1;
            end else begin
              n_q <= '0;
              if (last_m) begin
                m_q     <= '0;
                state_q <= IDLE;
              end else begin
                m_q <= m_q + 8'd1;
              end
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // tiles are stored K-major, 16 bytes each
  assign rd_addr_a_o = cfg_q.ptr_a +
      (addr_t'(m_q) * addr_t'(cfg_q.k) + addr_t'(k_q)) * addr_t'(TileBytes);
  assign rd_addr_b_o = cfg_q.ptr_b +
      (addr_t'(n_q) * addr_t'(cfg_q.k) + addr_t'(k_q)) * addr_t'(TileBytes);
  assign wr_addr_c_o = cfg_q.ptr_c +
      (addr_t'(m_q) * addr_t'(cfg_q.n) + addr_t'(n_q)) * addr_t'(TileBytes);

  assign rd_valid_o  = (state_q == RD_REQ);
  assign wr_valid_o  = (state_q == WRITE);
  assign busy_o      = (state_q != IDLE);
  // first K step of a C tile restarts the accumulators
  assign acc_clear_o = (state_q == RD_WAIT) && (k_q == '0);

  // tile data only arrives while a K step waits for it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    tile_valid_i |-> state_q == RD_WAIT);

endmodule

// File: source/grant_tracker.sv
`timescale 1ns/1ps

module grant_tracker #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic [NumPorts-1:0] q_ready_i,
  output logic [NumPorts-1:0] q_valid_o,
  output logic                all_granted_o
);

  logic [NumPorts-1:0] cap_q;
  logic [NumPorts-1:0] granted;

  // ports already granted stop requesting until the group completes
  assign q_valid_o     = {NumPorts{req_i}} & ~cap_q;
  assign granted       = q_valid_o & q_ready_i;
  assign all_granted_o = req_i && (&(cap_q | granted));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_q <= '0;
    end else if (!req_i || all_granted_o) begin
      cap_q <= '0;
    end else begin
      cap_q <= cap_q | granted;
    end
  end

  // the group request stays up until every port has been granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !all_granted_o |=> req_i);

endmodule

// File: source/read_collector.sv
`timescale 1ns/1ps

module read_collector
  import tcdm_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wait_i,
  input  tcdm_rsp_t [ReadPorts-1:0]  rsp_i,
  output logic                       tile_valid_o,
  output word_t     [ReadPorts-1:0]  tile_o
);

  logic  [ReadPorts-1:0] p_valid;
  logic  [ReadPorts-1:0] cap_q;
  word_t                 data_q [ReadPorts];

  always_comb begin
    for (int i = 0; i < ReadPorts; i++) begin
      p_valid[i] = rsp_i[i].p_valid;
      // a response in this cycle wins over the stored one
      tile_o[i]  = rsp_i[i].p_valid ? rsp_i[i].data : data_q[i];
    end
  end

  // early ports may answer while the others are still being granted
  assign tile_valid_o = wait_i && (&(cap_q | p_valid));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_q <= '0;
    end else if (tile_valid_o) begin
      cap_q <= '0;
    end else begin
      cap_q <= cap_q | p_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < ReadPorts; i++) begin
      if (rsp_i[i].p_valid) begin
        data_q[i] <= rsp_i[i].data;
      end
    end
  end

endmodule

// File: source/mac_array.sv
`timescale 1ns/1ps

module mac_array
  import gemm_cfg_pkg::*;
  import tcdm_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       tile_valid_i,
  input  logic                       acc_clear_i,
  input  elem_t                      sub_a_i,
  input  elem_t                      sub_b_i,
  input  word_t     [ReadPorts-1:0]  tile_i,
  output word_t     [WritePorts-1:0] c_o
);

  acc_t sum_d [TileRows][TileRows];
  acc_t acc_q [TileRows][TileRows];

  // dot products of A row r and B row c, zero points taken as signed int8
  always_comb begin
    logic signed [8:0]  da;
    logic signed [8:0]  db;
    logic signed [17:0] prod;
    logic signed [31:0] dot;
    for (int r = 0; r < TileRows; r++) begin
      for (int c = 0; c < TileRows; c++) begin
        dot = '0;
        for (int e = 0; e < TileDepth; e++) begin
          da   = $signed({tile_i[r][e*8+7], tile_i[r][e*8 +: 8]}) -
                 $signed({sub_a_i[7], sub_a_i});
          db   = $signed({tile_i[TileRows+c][e*8+7], tile_i[TileRows+c][e*8 +: 8]}) -
                 $signed({sub_b_i[7], sub_b_i});
          prod = da * db;
          dot  = dot + prod;
        end
        sum_d[r][c] = acc_t'(dot);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < TileRows; r++) begin
        for (int c = 0; c < TileRows; c++) begin
          acc_q[r][c] <= '0;
        end
      end
    end else if (tile_valid_i) begin
      for (int r = 0; r < TileRows; r++) begin
        for (int c = 0; c < TileRows; c++) begin
          acc_q[r][c] <= acc_clear_i ? sum_d[r][c] : acc_q[r][c] + sum_d[r][c];
        end
      end
    end
  end

  // one C row per write word, C00 in the low half
  always_comb begin
    for (int r = 0; r < WritePorts; r++) begin
      c_o[r] = {acc_q[r][1], acc_q[r][0]};
    end
  end

endmodule

// File: source/gemm_accel_top.sv
`timescale 1ns/1ps

module gemm_accel_top
  import gemm_cfg_pkg::*;
  import tcdm_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        csr_qvalid_i,
  output logic                        csr_qready_o,
  input  csr_req_t                    csr_req_i,
  output logic                        csr_pvalid_o,
  input  logic                        csr_pready_i,
  output csr_rsp_t                    csr_rsp_o,
  output tcdm_req_t [ReadPorts-1:0]   tcdm_rd_req_o,
  input  tcdm_rsp_t [ReadPorts-1:0]   tcdm_rd_rsp_i,
  output tcdm_req_t [WritePorts-1:0]  tcdm_wr_req_o,
  input  tcdm_rsp_t [WritePorts-1:0]  tcdm_wr_rsp_i,
  output logic                        barrier_o
);

  gemm_cfg_t               cfg;
  logic                    start;
  logic                    busy;
  logic                    rd_valid;
  logic                    wr_valid;
  logic                    rd_wait;
  logic                    acc_clear;
  logic                    rd_granted;
  logic                    wr_granted;
  logic                    tile_valid;
  addr_t                   rd_addr_a;
  addr_t                   rd_addr_b;
  addr_t                   wr_addr_c;
  logic  [ReadPorts-1:0]   rd_q_ready;
  logic  [ReadPorts-1:0]   rd_q_valid;
  logic  [WritePorts-1:0]  wr_q_ready;
  logic  [WritePorts-1:0]  wr_q_valid;
  word_t [ReadPorts-1:0]   tile;
  word_t [WritePorts-1:0]  c_words;

  csr_regfile u_csr (
    .clk_i, .rst_ni, .csr_qvalid_i, .csr_qready_o, .csr_req_i,
    .csr_pvalid_o, .csr_pready_i, .csr_rsp_o,
    .busy_i (busy), .cfg_o (cfg), .start_o (start)
  );

  tile_sequencer u_seq (
    .clk_i, .rst_ni, .cfg_i (cfg), .start_i (start),
    .rd_granted_i (rd_granted), .tile_valid_i (tile_valid), .wr_granted_i (wr_granted),
    .rd_valid_o (rd_valid), .wr_valid_o (wr_valid), .acc_clear_o (acc_clear),
    .busy_o (busy), .rd_addr_a_o (rd_addr_a), .rd_addr_b_o (rd_addr_b),
    .wr_addr_c_o (wr_addr_c)
  );

  // --------------------------------------------------
  // per-port contention handling
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < ReadPorts; i++) rd_q_ready[i] = tcdm_rd_rsp_i[i].q_ready;
    for (int i = 0; i < WritePorts; i++) wr_q_ready[i] = tcdm_wr_rsp_i[i].q_ready;
  end

  grant_tracker #(.NumPorts(ReadPorts)) u_rd_grant (
    .clk_i, .rst_ni, .req_i (rd_valid), .q_ready_i (rd_q_ready),
    .q_valid_o (rd_q_valid), .all_granted_o (rd_granted)
  );

  grant_tracker #(.NumPorts(WritePorts)) u_wr_grant (
    .clk_i, .rst_ni, .req_i (wr_valid), .q_ready_i (wr_q_ready),
    .q_valid_o (wr_q_valid), .all_granted_o (wr_granted)
  );

  // busy with neither request phase active means waiting on read data
  assign rd_wait = busy && !rd_valid && !wr_valid;

  read_collector u_collect (
    .clk_i, .rst_ni, .wait_i (rd_wait), .rsp_i (tcdm_rd_rsp_i),
    .tile_valid_o (tile_valid), .tile_o (tile)
  );

  mac_array u_mac (
    .clk_i, .rst_ni, .tile_valid_i (tile_valid), .acc_clear_i (acc_clear),
    .sub_a_i (cfg.sub_a), .sub_b_i (cfg.sub_b), .tile_i (tile), .c_o (c_words)
  );

  // --------------------------------------------------
  // tcdm requests
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < ReadPorts; i++) begin
      tcdm_rd_req_o[i] = '0;
      if (rd_q_valid[i]) begin
        tcdm_rd_req_o[i].q_valid = 1'b1;
        tcdm_rd_req_o[i].addr    = ((i < TileRows) ? rd_addr_a : rd_addr_b) +
                                   addr_t'((i % TileRows) * WordBytes);
      end
    end
    for (int i = 0; i < WritePorts; i++) begin
      tcdm_wr_req_o[i] = '0;
      if (wr_q_valid[i]) begin
        tcdm_wr_req_o[i].q_valid = 1'b1;
        tcdm_wr_req_o[i].addr    = wr_addr_c + addr_t'(i * WordBytes);
        tcdm_wr_req_o[i].write   = 1'b1;
        tcdm_wr_req_o[i].data    = c_words[i];
        tcdm_wr_req_o[i].strb    = '1;
      end
    end
  end

  assign barrier_o = !busy;

endmodule

// File: verification/tb_gemm_accel.sv
`timescale 1ns/1ps

module tb_gemm_accel
  import gemm_cfg_pkg::*;
  import tcdm_pkg::*;
;

  typedef struct {
    string name;
    int    m;
    int    k;
    int    n;
    elem_t sub_a;
    elem_t sub_b;
    int    stall;
    bit    bp;
    bit    reuse;
  } test_row_t;

  localparam int NumTests = 7;

  logic                       clk_i = 1'b0;
  logic                       rst_ni;
  logic                       csr_qvalid_i;
  logic                       csr_qready_o;
  csr_req_t                   csr_req_i;
  logic                       csr_pvalid_o;
  logic                       csr_pready_i;
  csr_rsp_t                   csr_rsp_o;
  tcdm_req_t [ReadPorts-1:0]  rd_req;
  tcdm_rsp_t [ReadPorts-1:0]  rd_rsp;
  tcdm_req_t [WritePorts-1:0] wr_req;
  tcdm_rsp_t [WritePorts-1:0] wr_rsp;
  logic                       barrier_o;

  test_row_t   tests [NumTests];
  logic [7:0]  mem [addr_t];
  logic [31:0] lfsr_q = 32'h9673e3bd;
  int          cur_stall = 0;
  int          rd_pend [ReadPorts];
  word_t       rd_word [ReadPorts];
  acc_t        exp_c [64];
  acc_t        prev_c [64];
  logic [4:0]  next_id = '0;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 0;

  gemm_accel_top u_dut (
    .clk_i, .rst_ni, .csr_qvalid_i, .csr_qready_o, .csr_req_i,
    .csr_pvalid_o, .csr_pready_i, .csr_rsp_o,
    .tcdm_rd_req_o (rd_req), .tcdm_rd_rsp_i (rd_rsp),
    .tcdm_wr_req_o (wr_req), .tcdm_wr_rsp_i (wr_rsp), .barrier_o
  );

  always #4 clk_i = !clk_i;

  // --------------------------------------------------
  // random source and error handling
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return r;
  endfunction

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_csr(string name, csr_data_t exp, csr_data_t act);
    if (exp !== act) stop_on_error($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_acc(string name, acc_t exp, acc_t act);
    if (exp !== act) stop_on_error($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_id(string name, logic [4:0] exp, logic [4:0] act);
    if (exp !== act) stop_on_error($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      stop_on_error("timeout: the run did not finish within the cycle limit");
    end
  end

  // --------------------------------------------------
  // tcdm memory model
  // --------------------------------------------------
  function automatic word_t read_word(addr_t a);
    word_t w;
    for (int j = 0; j < 8; j++) w[j*8 +: 8] = mem[a + addr_t'(j)];
    return w;
  endfunction

  function automatic logic draw_ready();
    if (cur_stall == 0) return 1'b1;
    if (cur_stall == 1) return take_bits(1) == 1;
    return take_bits(2) == 3;
  endfunction

  always @(posedge clk_i) begin
    for (int p = 0; p < ReadPorts; p++) begin
      rd_rsp[p].p_valid <= (rd_pend[p] == 1);
      rd_rsp[p].data    <= (rd_pend[p] == 1) ? rd_word[p] : '0;
      if (rd_pend[p] != 0) rd_pend[p] = rd_pend[p] - 1;
      if (rd_req[p].q_valid && rd_rsp[p].q_ready) begin
        if (rd_req[p].write) stop_on_error("read port request has the write bit set");
        rd_word[p] = read_word(rd_req[p].addr);
        rd_pend[p] = (cur_stall == 0) ? 1 : 1 + int'(take_bits(2) % 3);
      end
      rd_rsp[p].q_ready <= draw_ready();
    end
    for (int p = 0; p < WritePorts; p++) begin
      if (wr_req[p].q_valid && wr_rsp[p].q_ready) begin
        if (!wr_req[p].write) stop_on_error("write port request without the write bit set");
        // only strobed bytes are stored
        for (int j = 0; j < 8; j++) begin
          if (wr_req[p].strb[j]) mem[wr_req[p].addr + addr_t'(j)] = wr_req[p].data[j*8 +: 8];
        end
      end
      wr_rsp[p].q_ready <= draw_ready();
    end
  end

  // --------------------------------------------------
  // csr driver
  // --------------------------------------------------
  task automatic csr_write(csr_addr_t addr, csr_data_t data);
    csr_qvalid_i <= 1'b1;
    csr_req_i    <= '{write: 1'b1, addr: addr, wdata: data, id: 5'd0};
    do @(posedge clk_i); while (!csr_qready_o);
    csr_qvalid_i <= 1'b0;
  endtask

  task automatic csr_read(csr_addr_t addr, bit bp, output csr_rsp_t rsp);
    logic [4:0] id;
    id           = next_id;
    next_id      = next_id + 5'd1;
    csr_qvalid_i <= 1'b1;
    csr_req_i    <= '{write: 1'b0, addr: addr, wdata: '0, id: id};
    csr_pready_i <= !bp;
    do @(posedge clk_i); while (!csr_qready_o);
    csr_qvalid_i <= 1'b0;
    @(posedge clk_i);
    if (!csr_pvalid_o) stop_on_error("csr read response missing in the cycle after acceptance");
    rsp = csr_rsp_o;
    if (bp) begin
      repeat (3) begin
        @(posedge clk_i);
        if (!csr_pvalid_o || csr_rsp_o !== rsp) begin
          stop_on_error("csr response dropped or changed while pready was low");
        end
      end
      csr_pready_i <= 1'b1;
      @(posedge clk_i);
    end
    check_id($sformatf("id of read %h", addr), id, rsp.id);
  endtask

  task automatic read_check(string name, csr_addr_t addr, csr_data_t exp, bit bp);
    csr_rsp_t rsp;
    csr_read(addr, bp, rsp);
    check_csr(name, exp, rsp.rdata);
  endtask

  function automatic acc_t read_acc(addr_t a);
    acc_t v;
    for (int j = 0; j < 4; j++) v[j*8 +: 8] = mem[a + addr_t'(j)];
    return v;
  endfunction

  // --------------------------------------------------
  // one table row
  // --------------------------------------------------
  task automatic run_test(int t);
    test_row_t tr;
    addr_t     pa;
    addr_t     pb;
    addr_t     pc;
    addr_t     a;
    int        dot;
    int        idx;
    csr_rsp_t  rsp;
    tr = tests[t];
    pa = 32'h1000;
    pb = 32'h4000;
    pc = 32'h8000 + addr_t'(t) * 32'h400;
    if (!tr.reuse) begin
      for (int i = 0; i < tr.m * tr.k * 16; i++) mem[pa + addr_t'(i)] = 8'(take_bits(8));
      for (int i = 0; i < tr.n * tr.k * 16; i++) mem[pb + addr_t'(i)] = 8'(take_bits(8));
    end
    // stale C contents, derived from the address
    for (int i = 0; i < tr.m * tr.n * 16; i++) begin
      a      = pc + addr_t'(i);
      mem[a] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    end
    // reference model, signed int8 with zero points
    for (int m = 0; m < tr.m; m++) begin
      for (int n = 0; n < tr.n; n++) begin
        for (int r = 0; r < 2; r++) begin
          for (int c = 0; c < 2; c++) begin
            dot = 0;
            for (int k = 0; k < tr.k; k++) begin
              for (int e = 0; e < 8; e++) begin
                dot += (int'($signed(mem[pa + addr_t'((m * tr.k + k) * 16 + r * 8 + e)]))
                        - int'($signed(tr.sub_a))) *
                       (int'($signed(mem[pb + addr_t'((n * tr.k + k) * 16 + c * 8 + e)]))
                        - int'($signed(tr.sub_b)));
              end
            end
            exp_c[(m * tr.n + n) * 4 + r * 2 + c] = acc_t'(dot);
          end
        end
      end
    end

    csr_write(CsrSize, {8'h00, 8'(tr.m), 8'(tr.k), 8'(tr.n)});
    csr_write(CsrPtrA, pa);
    csr_write(CsrPtrB, pb);
    csr_write(CsrPtrC, pc);
    csr_write(CsrSub, {16'h0000, tr.sub_b, tr.sub_a});
    read_check({tr.name, " size"}, CsrSize, {8'h00, 8'(tr.m), 8'(tr.k), 8'(tr.n)}, tr.bp);
    read_check({tr.name, " ptr_a"}, CsrPtrA, pa, tr.bp);
    read_check({tr.name, " ptr_b"}, CsrPtrB, pb, 1'b0);
    read_check({tr.name, " ptr_c"}, CsrPtrC, pc, 1'b0);
    read_check({tr.name, " sub"}, CsrSub, {16'h0000, tr.sub_b, tr.sub_a}, tr.bp);
    read_check({tr.name, " unmapped"}, 12'h3c7, 32'h0, 1'b0);

    cur_stall = tr.stall;
    csr_write(CsrState, 32'h1);
    @(posedge clk_i);
    if (barrier_o) stop_on_error($sformatf("%s: barrier did not fall after start", tr.name));
    // a second state write must wait for the end of the run
    csr_qvalid_i <= 1'b1;
    csr_req_i    <= '{write: 1'b1, addr: CsrState, wdata: 32'h0, id: 5'd0};
    do @(posedge clk_i); while (!csr_qready_o);
    csr_qvalid_i <= 1'b0;
    if (!barrier_o) stop_on_error($sformatf("%s: state write accepted while busy", tr.name));
    cur_stall = 0;

    for (int i = 0; i < tr.m * tr.n * 4; i++) begin
      idx = i;
      a   = pc + addr_t'((i / 4) * 16 + ((i / 2) % 2) * 8 + (i % 2) * 4);
      if (tr.reuse) check_acc($sformatf("%s rerun c[%0d]", tr.name, idx), prev_c[i], read_acc(a));
      check_acc($sformatf("%s c[%0d]", tr.name, idx), exp_c[i], read_acc(a));
      prev_c[i] = read_acc(a);
    end

    csr_read(CsrPerf, 1'b0, rsp);
    if (rsp.rdata < csr_data_t'(tr.m * tr.n * (2 * tr.k + 1))) begin
      stop_on_error($sformatf("%s: perf counter %0d is below the minimum run length",
                              tr.name, rsp.rdata));
    end
    read_check({tr.name, " state"}, CsrState, 32'h2, 1'b0);
  endtask

  function automatic int stall_factor(int s);
    return (s == 0) ? 1 : ((s == 1) ? 4 : 16);
  endfunction

  initial begin
    tests[0] = '{"tile_1x1x1", 1, 1, 1, 8'h00, 8'h00, 0, 1'b0, 1'b0};
    tests[1] = '{"tile_2x3x2", 2, 3, 2, 8'h00, 8'h00, 0, 1'b1, 1'b0};
    tests[2] = '{"tile_3x4x2", 3, 4, 2, 8'h00, 8'h00, 0, 1'b0, 1'b0};
    tests[3] = '{"zero_point", 2, 2, 2, 8'h05, 8'hfb, 0, 1'b0, 1'b0};
    tests[4] = '{"zero_point_stall", 2, 2, 2, 8'h05, 8'hfb, 2, 1'b1, 1'b1};
    tests[5] = '{"mid_stall", 3, 4, 2, 8'h80, 8'h7f, 1, 1'b0, 1'b0};
    tests[6] = '{"heavy_stall", 3, 4, 2, 8'h80, 8'h7f, 2, 1'b1, 1'b1};

    cycle_limit = 2000;
    for (int t = 0; t < NumTests; t++) begin
      cycle_limit += 8 * tests[t].m * tests[t].n * (2 * tests[t].k + 1) *
                     stall_factor(tests[t].stall);
    end

    rst_ni       = 1'b0;
    csr_qvalid_i = 1'b0;
    csr_req_i    = '0;
    csr_pready_i = 1'b1;
    rd_rsp       = '0;
    wr_rsp       = '0;
    for (int p = 0; p < ReadPorts; p++) rd_pend[p] = 0;

    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    if (!barrier_o || csr_pvalid_o) stop_on_error("wrong barrier or pvalid after reset");
    for (int p = 0; p < ReadPorts; p++) begin
      if (rd_req[p].q_valid) stop_on_error("read request active after reset");
    end
    for (int p = 0; p < WritePorts; p++) begin
      if (wr_req[p].q_valid) stop_on_error("write request active after reset");
    end
    read_check("reset state", CsrState, 32'h2, 1'b0);

    for (int t = 0; t < NumTests; t++) run_test(t);

    $display("sim passed");
    $finish;
  end

endmodule

// File: vlog.f
source/gemm_cfg_pkg.sv
source/tcdm_pkg.sv
source/csr_regfile.sv
source/tile_sequencer.sv
source/grant_tracker.sv
source/read_collector.sv
source/mac_array.sv
source/gemm_accel_top.sv
verification/tb_gemm_accel.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the gemm accelerator testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_gemm_accel -Mdir build -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./build/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0
